// File: ringBusPkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// ring bus types shared by the caches and the MMU
// opcodes, request and response layouts, fixed codes
// ~~~~~~~~~~~~~~~~~~~~
package ringBusPkg;

	typedef logic [47:0] virtAddr;
	typedef logic [47:0] physAddr;
	typedef logic [127:0] lineData;
	typedef logic [15:0] seqTag;
	typedef logic [15:0] excCode;

	// memory access group 9x/Ax, TLB commands in 8x
	typedef enum logic [7:0]
	{
		opIdle = 8'h00,
		opLoad = 8'h91,
		opStore = 8'hA1,
		opLdtlb = 8'h81,
		opInvtlb = 8'h82
	} busOp;

	// LDTLB carries the physical address in data[47:0]
	typedef struct packed
	{
		busOp op;
		seqTag seq;
		virtAddr addr;
		lineData data;
	} busRequest;

	typedef struct packed
	{
		busOp op;
		seqTag seq;
		physAddr addr;
		lineData data;
		excCode exc;
		virtAddr faultAddr;
	} busResponse;

	localparam excCode TlbMissExc = 16'hA001;
	// misses are steered to this page, keeping the 4K offset
	localparam physAddr MissPageAddr = 48'h010000;

	// top address nibble windows
	localparam logic [3:0] PhysWindowC = 4'hC;
	localparam logic [3:0] PhysWindowD = 4'hD;
	localparam logic [3:0] MmioWindow = 4'hF;

endpackage

// File: tlbPkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// translation buffer types
// page sizes, MMU control and entry layout
// ~~~~~~~~~~~~~~~~~~~~
package tlbPkg;

	typedef enum logic [1:0]
	{
		page4k = 2'd0,
		page16k = 2'd1,
		page64k = 2'd2
	} pageSize;

	typedef struct packed
	{
		logic enable;
		pageSize size;
	} mmuControl;

	// generation counter, bumped by INVTLB
	typedef logic [7:0] rover;

	// address bits 47..12
	typedef logic [35:0] pageNumber;

	typedef struct packed
	{
		rover gen;
		pageNumber virtPage;
		pageNumber physPage;
	} tlbEntry;

	// offset widths of the three page sizes
	localparam int PageShift4k = 12;
	localparam int PageShift16k = 14;
	localparam int PageShift64k = 16;

	// page number bits that fall inside a larger page
	localparam pageNumber PageMask4k = 36'h0;
	localparam pageNumber PageMask16k = 36'h3;
	localparam pageNumber PageMask64k = 36'hF;

endpackage

// File: tlbSetIndex.sv
// ~~~~~~~~~~~~~~~~~~~~
// lookup stage of the TLB: picks the set for the ways
// and registers the request beside the way read
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tlbSetIndex
#(
	parameter int IndexBits = 6
)
(
	input logic clock,
	input logic reset,
	input logic hold,
	input ringBusPkg::busRequest request,
	input tlbPkg::mmuControl control,
	output ringBusPkg::busRequest stageRequest,
	output tlbPkg::mmuControl stageControl,
	output logic [IndexBits-1:0] readIndex
);

	if (IndexBits < 4 || IndexBits > 10)
	begin : badIndexBits
		$error("IndexBits must lie between 4 and 10");
	end

	// index bits sit just above the page offset
	always_comb
	begin
		case (control.size)
			tlbPkg::page16k:
				readIndex = request.addr[tlbPkg::PageShift16k +: IndexBits];
			tlbPkg::page64k:
				readIndex = request.addr[tlbPkg::PageShift64k +: IndexBits];
			default:
				readIndex = request.addr[tlbPkg::PageShift4k +: IndexBits];
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			stageRequest.op <= ringBusPkg::opIdle;
			stageControl <= '0;
		end
		else if (!hold)
		begin
			stageRequest <= request;
			stageControl <= control;
		end
	end

	// a request only comes with one of the three page sizes
	assert property (@(posedge clock) disable iff (reset)
		request.op != ringBusPkg::opIdle |->
		control.size inside {tlbPkg::page4k, tlbPkg::page16k, tlbPkg::page64k});

endmodule

// File: tlbWay.sv
// ~~~~~~~~~~~~~~~~~~~~
// one TLB way: entry store, registered read, tag compare
// a write lands at the set read in the previous cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tlbWay
#(
	parameter int IndexBits = 6
)
(
	input logic clock,
	input logic reset,
	input logic hold,
	input logic [IndexBits-1:0] readIndex,
	input ringBusPkg::busRequest stageRequest,
	input tlbPkg::mmuControl stageControl,
	input tlbPkg::rover currentRover,
	input logic writeEnable,
	input tlbPkg::tlbEntry writeEntry,
	output logic wayHit,
	output tlbPkg::tlbEntry wayEntry
);

	localparam int Sets = 2 ** IndexBits;

	tlbPkg::tlbEntry entries [Sets];
	logic [Sets-1:0] valid;
	logic [IndexBits-1:0] stageIndex;
	tlbPkg::tlbEntry readEntry;
	logic readValid;
	logic forward;
	logic writeValid;
	tlbPkg::pageNumber pageMask;
	tlbPkg::pageNumber stagePage;

	// read of the set being written sees the new entry
	assign forward = writeEnable && (readIndex == stageIndex);

	// a shifted entry from an old generation stays dead
	assign writeValid = (writeEntry.gen == currentRover);

	always_ff @(posedge clock)
	begin
		if (writeEnable)
			entries[stageIndex] <= writeEntry;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid <= '0;
			readValid <= 1'b0;
			stageIndex <= '0;
		end
		else
		begin
			if (writeEnable)
				valid[stageIndex] <= writeValid;
			if (!hold)
			begin
				stageIndex <= readIndex;
				readValid <= forward ? writeValid : valid[readIndex];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			readEntry <= forward ? writeEntry : entries[readIndex];
	end

	always_comb
	begin
		case (stageControl.size)
			tlbPkg::page16k:
				pageMask = tlbPkg::PageMask16k;
			tlbPkg::page64k:
				pageMask = tlbPkg::PageMask64k;
			default:
				pageMask = tlbPkg::PageMask4k;
		endcase
	end

	assign stagePage = stageRequest.addr[47:tlbPkg::PageShift4k];

	assign wayHit = readValid && (readEntry.gen == currentRover) &&
		(((readEntry.virtPage ^ stagePage) & ~pageMask) == '0);

	// empty slots go out marked with a foreign generation
	always_comb
	begin
		wayEntry = readEntry;
		if (!readValid)
		begin
			wayEntry = '0;
			wayEntry.gen = ~currentRover;
		end
	end

	// translate stage only writes while the pipeline moves
	assert property (@(posedge clock) disable iff (reset) hold |-> !writeEnable);

endmodule

// File: tlbTranslate.sv
// ~~~~~~~~~~~~~~~~~~~~
// translate stage: picks the hitting way, forms the
// outgoing address and writes the set back reordered
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tlbTranslate
(
	input logic clock,
	input logic reset,
	input logic hold,
	input ringBusPkg::busRequest stageRequest,
	input tlbPkg::mmuControl stageControl,
	input logic [3:0] wayHit,
	input tlbPkg::tlbEntry [3:0] wayEntry,
	output logic [3:0] writeEnable,
	output tlbPkg::tlbEntry [3:0] writeEntry,
	output tlbPkg::rover currentRover,
	output ringBusPkg::busResponse response
);

	logic isAccess;
	logic isLdtlb;
	logic isInvtlb;
	logic inPhysWindow;
	logic inMmioWindow;
	logic translateOn;
	logic hitAny;
	logic [1:0] hitWay;
	tlbPkg::tlbEntry hitEntry;
	tlbPkg::tlbEntry loadEntry;
	ringBusPkg::physAddr formedAddr;
	ringBusPkg::busResponse nextResponse;

	assign isAccess = (stageRequest.op == ringBusPkg::opLoad) ||
		(stageRequest.op == ringBusPkg::opStore);
	assign isLdtlb = (stageRequest.op == ringBusPkg::opLdtlb);
	assign isInvtlb = (stageRequest.op == ringBusPkg::opInvtlb);

	assign inPhysWindow = (stageRequest.addr[47:44] == ringBusPkg::PhysWindowC) ||
		(stageRequest.addr[47:44] == ringBusPkg::PhysWindowD);
	assign inMmioWindow = (stageRequest.addr[47:44] == ringBusPkg::MmioWindow);

	// only plain loads and stores outside the windows translate
	assign translateOn = stageControl.enable && isAccess && !inPhysWindow && !inMmioWindow;

	// lowest hitting way wins
	always_comb
	begin
		hitWay = 2'd0;
		for (int i = 3; i >= 0; i--)
		begin
			if (wayHit[i])
				hitWay = 2'(i);
		end
	end

	assign hitAny = |wayHit;
	assign hitEntry = wayEntry[hitWay];

	always_comb
	begin
		formedAddr = {hitEntry.physPage, stageRequest.addr[tlbPkg::PageShift4k-1:0]};
		if (stageControl.size != tlbPkg::page4k)
			formedAddr[13:12] = stageRequest.addr[13:12];
		if (stageControl.size == tlbPkg::page64k)
			formedAddr[15:14] = stageRequest.addr[15:14];
		// low physical pages are reached through window C
		if (formedAddr[47:44] == 4'h0)
			formedAddr[47:44] = ringBusPkg::PhysWindowC;
	end

	always_comb
	begin
		nextResponse.op = stageRequest.op;
		nextResponse.seq = stageRequest.seq;
		nextResponse.addr = stageRequest.addr;
		nextResponse.data = stageRequest.data;
		nextResponse.exc = '0;
		nextResponse.faultAddr = '0;
		if (stageControl.enable && isAccess && inPhysWindow)
			nextResponse.addr[47:44] = ringBusPkg::PhysWindowC;
		if (translateOn && hitAny)
			nextResponse.addr = formedAddr;
		else if (translateOn)
		begin
			// miss goes to the handler page with the 4K offset
			nextResponse.addr = {ringBusPkg::MissPageAddr[47:12],
				stageRequest.addr[tlbPkg::PageShift4k-1:0]};
			nextResponse.exc = ringBusPkg::TlbMissExc;
			nextResponse.faultAddr = stageRequest.addr;
		end
	end

	assign loadEntry.gen = currentRover;
	assign loadEntry.virtPage = stageRequest.addr[47:tlbPkg::PageShift4k];
	assign loadEntry.physPage = stageRequest.data[47:tlbPkg::PageShift4k];

	always_comb
	begin
		writeEnable = '0;
		writeEntry = wayEntry;
		if (isLdtlb)
		begin
			// new entry in front, way 3 falls out
			writeEnable = 4'hF;
			writeEntry[0] = loadEntry;
			for (int i = 1; i < 4; i++)
				writeEntry[i] = wayEntry[i-1];
		end
		else if (translateOn && hitAny && hitWay != 2'd0)
		begin
			// move to front, ways above the hit slide down
			writeEnable[0] = 1'b1;
			writeEntry[0] = hitEntry;
			for (int i = 1; i < 4; i++)
			begin
				if (i <= int'(hitWay))
				begin
					writeEnable[i] = 1'b1;
					writeEntry[i] = wayEntry[i-1];
				end
			end
		end
		if (hold)
			writeEnable = '0;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			currentRover <= '0;
		else if (!hold && isInvtlb)
			currentRover <= currentRover + 8'd1;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			response.op <= ringBusPkg::opIdle;
			response.exc <= '0;
		end
		else if (!hold)
			response <= nextResponse;
	end

	// a page never sits in two ways of one set
	assert property (@(posedge clock) disable iff (reset) $onehot0(wayHit));

endmodule

// File: mmuTlb.sv
// ~~~~~~~~~~~~~~~~~~~~
// four-way TLB between L1 and L2 on the ring bus
// virtual request in, physical request out two edges later
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mmuTlb
#(
	parameter int IndexBits = 6
)
(
	input logic clock,
	input logic reset,
	input logic hold,
	input ringBusPkg::busRequest request,
	input tlbPkg::mmuControl control,
	output ringBusPkg::busResponse response
);

	ringBusPkg::busRequest stageRequest;
	tlbPkg::mmuControl stageControl;
	logic [IndexBits-1:0] readIndex;
	tlbPkg::rover currentRover;
	logic [3:0] wayHit;
	tlbPkg::tlbEntry [3:0] wayEntry;
	logic [3:0] writeEnable;
	tlbPkg::tlbEntry [3:0] writeEntry;

	tlbSetIndex #(.IndexBits(IndexBits)) setIndex
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.request(request),
		.control(control),
		.stageRequest(stageRequest),
		.stageControl(stageControl),
		.readIndex(readIndex)
	);

	for (genvar i = 0; i < 4; i++)
	begin : wayGen
		tlbWay #(.IndexBits(IndexBits)) way
		(
			.clock(clock),
			.reset(reset),
			.hold(hold),
			.readIndex(readIndex),
			.stageRequest(stageRequest),
			.stageControl(stageControl),
			.currentRover(currentRover),
			.writeEnable(writeEnable[i]),
			.writeEntry(writeEntry[i]),
			.wayHit(wayHit[i]),
			.wayEntry(wayEntry[i])
		);
	end

	tlbTranslate translate
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.stageRequest(stageRequest),
		.stageControl(stageControl),
		.wayHit(wayHit),
		.wayEntry(wayEntry),
		.writeEnable(writeEnable),
		.writeEntry(writeEntry),
		.currentRover(currentRover),
		.response(response)
	);

endmodule

// File: tlbCases.svh
// ~~~~~~~~~~~~~~~~~~~~
// TLB case rows, the row number is the request seq
// columns: control, op, address, LDTLB data, hold cycles, expected address, expected exc
// ~~~~~~~~~~~~~~~~~~~~
// MMU off, addresses pass unchanged
addCase(CtlOff, OpLoad, 48'h1234_5678_9000, 48'h0, 0, 48'h1234_5678_9000, 16'h0);
addCase(CtlOff, OpStore, 48'hD000_0000_4000, 48'h0, 0, 48'hD000_0000_4000, 16'h0);
// physical windows and MMIO
addCase(Ctl4k, OpLoad, 48'hC012_3456_7000, 48'h0, 0, 48'hC012_3456_7000, 16'h0);
addCase(Ctl4k, OpStore, 48'hD0AB_CDEF_0000, 48'h0, 0, 48'hC0AB_CDEF_0000, 16'h0);
addCase(Ctl4k, OpLoad, 48'hF000_1234_5000, 48'h0, 0, 48'hF000_1234_5000, 16'h0);
// miss on an empty set
addCase(Ctl4k, OpLoad, 48'h0000_7777_7000, 48'h0, 0, 48'h0000_0001_0000, MissExc);
// 4K mapping, zero top nibble leaves as C
addCase(Ctl4k, OpLdtlb, 48'h0000_1234_5000, 48'h0000_0ABC_D000, 0, 48'h0000_1234_5000, 16'h0);
addCase(Ctl4k, OpLoad, 48'h0000_1234_5000, 48'h0, 0, 48'hC000_0ABC_D000, 16'h0);
// 16K mapping, bits 13..12 from the virtual address
addCase(Ctl16k, OpLdtlb, 48'h0000_4444_0000, 48'h2000_5555_0000, 0, 48'h0000_4444_0000, 16'h0);
addCase(Ctl16k, OpLoad, 48'h0000_4444_3000, 48'h0, 0, 48'h2000_5555_3000, 16'h0);
addCase(Ctl16k, OpLoad, 48'h0000_4444_1000, 48'h0, 0, 48'h2000_5555_1000, 16'h0);
// five loads into set 3, first one falls out
addCase(Ctl4k, OpLdtlb, 48'h0000_1000_3000, 48'h0000_0A01_0000, 0, 48'h0000_1000_3000, 16'h0);
addCase(Ctl4k, OpLdtlb, 48'h0000_2000_3000, 48'h0000_0A02_0000, 0, 48'h0000_2000_3000, 16'h0);
addCase(Ctl4k, OpLdtlb, 48'h0000_3000_3000, 48'h0000_0A03_0000, 0, 48'h0000_3000_3000, 16'h0);
addCase(Ctl4k, OpLdtlb, 48'h0000_4000_3000, 48'h0000_0A04_0000, 0, 48'h0000_4000_3000, 16'h0);
addCase(Ctl4k, OpLdtlb, 48'h0000_5000_3000, 48'h0000_0A05_0000, 0, 48'h0000_5000_3000, 16'h0);
addCase(Ctl4k, OpLoad, 48'h0000_1000_3000, 48'h0, 0, 48'h0000_0001_0000, MissExc);
addCase(Ctl4k, OpLoad, 48'h0000_2000_3000, 48'h0, 0, 48'hC000_0A02_0000, 16'h0);
// set 7, oldest entry promoted before the fifth load
addCase(Ctl4k, OpLdtlb, 48'h0000_1100_7000, 48'h0000_0B01_0000, 0, 48'h0000_1100_7000, 16'h0);
addCase(Ctl4k, OpLdtlb, 48'h0000_2200_7000, 48'h0000_0B02_0000, 0, 48'h0000_2200_7000, 16'h0);
addCase(Ctl4k, OpLdtlb, 48'h0000_3300_7000, 48'h0000_0B03_0000, 0, 48'h0000_3300_7000, 16'h0);
addCase(Ctl4k, OpLdtlb, 48'h0000_4400_7000, 48'h0000_0B04_0000, 0, 48'h0000_4400_7000, 16'h0);
addCase(Ctl4k, OpLoad, 48'h0000_1100_7000, 48'h0, 0, 48'hC000_0B01_0000, 16'h0);
addCase(Ctl4k, OpLdtlb, 48'h0000_5500_7000, 48'h0000_0B05_0000, 0, 48'h0000_5500_7000, 16'h0);
addCase(Ctl4k, OpLoad, 48'h0000_1100_7000, 48'h0, 0, 48'hC000_0B01_0000, 16'h0);
addCase(Ctl4k, OpLoad, 48'h0000_2200_7000, 48'h0, 0, 48'h0000_0001_0000, MissExc);
// invalidate all under hold, then reload
addCase(Ctl4k, OpInvtlb, 48'h0, 48'h0, 5, 48'h0, 16'h0);
addCase(Ctl4k, OpLoad, 48'h0000_1234_5000, 48'h0, 3, 48'h0000_0001_0000, MissExc);
addCase(Ctl4k, OpLoad, 48'h0000_1100_7000, 48'h0, 0, 48'h0000_0001_0000, MissExc);
addCase(Ctl4k, OpLdtlb, 48'h0000_1234_5000, 48'h0000_0DEF_0000, 4, 48'h0000_1234_5000, 16'h0);
addCase(Ctl4k, OpLoad, 48'h0000_1234_5000, 48'h0, 6, 48'hC000_0DEF_0000, 16'h0);

// File: mmuTlbTb.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the ring bus TLB, runs the case table
// from tlbCases.svh and checks every response
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mmuTlbTb;

	typedef struct packed
	{
		tlbPkg::mmuControl control;
		ringBusPkg::busOp op;
		ringBusPkg::virtAddr addr;
		logic [47:0] data;
		int holdLen;
		ringBusPkg::physAddr expAddr;
		ringBusPkg::excCode expExc;
	} caseRow;

	localparam tlbPkg::mmuControl CtlOff = '{enable: 1'b0, size: tlbPkg::page4k};
	localparam tlbPkg::mmuControl Ctl4k = '{enable: 1'b1, size: tlbPkg::page4k};
	localparam tlbPkg::mmuControl Ctl16k = '{enable: 1'b1, size: tlbPkg::page16k};
	localparam ringBusPkg::busOp OpLoad = ringBusPkg::opLoad;
	localparam ringBusPkg::busOp OpStore = ringBusPkg::opStore;
	localparam ringBusPkg::busOp OpLdtlb = ringBusPkg::opLdtlb;
	localparam ringBusPkg::busOp OpInvtlb = ringBusPkg::opInvtlb;
	localparam ringBusPkg::excCode MissExc = ringBusPkg::TlbMissExc;
	localparam int CycleLimit = 20;

	logic clock;
	logic reset;
	logic hold;
	ringBusPkg::busRequest request;
	tlbPkg::mmuControl control;
	ringBusPkg::busResponse response;
	caseRow caseTable[$];
	integer seed;

	mmuTlb dut_i
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.request(request),
		.control(control),
		.response(response)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#20 clock = ~clock;
	end

	function automatic void addCase(input tlbPkg::mmuControl ctl, input ringBusPkg::busOp op,
		input logic [47:0] addr, input logic [47:0] data, input int holdLen,
		input logic [47:0] expAddr, input logic [15:0] expExc);
		caseRow row;
		row.control = ctl;
		row.op = op;
		row.addr = addr;
		row.data = data;
		row.holdLen = holdLen;
		row.expAddr = expAddr;
		row.expExc = expExc;
		caseTable.push_back(row);
	endfunction

	function automatic void buildTable();
		`include "tlbCases.svh"
	endfunction

	task automatic check(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (actual !== expected)
		begin
			$display("ERROR %s expected %h got %h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic runCase(input int idx);
		caseRow row;
		logic [11:0] offset;
		ringBusPkg::virtAddr vaddr;
		ringBusPkg::physAddr expAddr;
		ringBusPkg::busResponse frozen;
		int waited;
		row = caseTable[idx];
		offset = '0;
		// loads and stores get a random 4K offset, carried through unchanged
		if (row.op == OpLoad || row.op == OpStore)
			offset = 12'($random(seed));
		vaddr = row.addr | {36'h0, offset};
		expAddr = row.expAddr | {36'h0, offset};
		control = row.control;
		request.op = row.op;
		request.seq = 16'(idx);
		request.addr = vaddr;
		request.data = {80'h0, row.data};
		@(negedge clock);
		request.op = ringBusPkg::opIdle;
		// freeze the pipeline with the request in the lookup stage
		frozen = response;
		hold = (row.holdLen > 0);
		for (int h = 0; h < row.holdLen; h++)
		begin
			@(negedge clock);
			check("held response.addr", frozen.addr, response.addr);
			check("held response.op", 48'(frozen.op), 48'(response.op));
		end
		hold = 1'b0;
		waited = 0;
		while (response.op === ringBusPkg::opIdle || response.seq !== 16'(idx))
		begin
			if (waited == CycleLimit)
			begin
				$display("TB FAILED");
				$fatal(1, "timeout waiting for the response to case %0d", idx);
			end
			waited++;
			@(negedge clock);
		end
		check("response.op", 48'(row.op), 48'(response.op));
		check("response.addr", expAddr, response.addr);
		check("response.data", {80'h0, row.data}, response.data);
		check("response.exc", 48'(row.expExc), 48'(response.exc));
		check("response.faultAddr", (row.expExc != 16'h0) ? vaddr : 48'h0,
			response.faultAddr);
	endtask

	initial
	begin
		seed = 32'h6fe6;
		reset = 1'b1;
		hold = 1'b0;
		request = '0;
		control = CtlOff;
		buildTable();
		repeat (16)
			@(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < caseTable.size(); i++)
			runCase(i);
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
ringBusPkg.sv
tlbPkg.sv
tlbSetIndex.sv
tlbWay.sv
tlbTranslate.sv
mmuTlb.sv
mmuTlbTb.sv

// File: run.sh
#!/bin/sh
# builds the TLB testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module mmuTlbTb -f filelist.f -o mmuTlbSim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed"
	exit $status
fi

./obj_dir/mmuTlbSim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi

exit 0
